// ==== sim.f ====
source/issue_pkg.sv
source/inst_decoder.sv
source/regfile.sv
source/map_table.sv
source/reorder_buf.sv
source/issue_stage.sv
source/issue_top.sv
test/tb_issue.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_issue -f sim.f \
	&& ./obj_dir/Vtb_issue > sim.log 2>&1 \
	|| echo "TEST FAILED" >> sim.log
cat sim.log
! grep -q "TEST FAILED" sim.log

// ==== test/tb_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_issue import issue_pkg::*; ();

	localparam int TAG_BITS = 3;
	localparam int LAST_TAG = 7;
	localparam int TEST_INSTS = 90;
	localparam longint TIMEOUT_NS = (16 + 40 * TEST_INSTS) * 20;

	logic clock, rst_n, inst_valid, complete_valid;
	logic [31:0] inst, complete_data;
	logic [TAG_BITS-1:0] complete_tag;
	opa_sel_e opa_sel;
	opb_sel_e opb_sel;
	alu_func_e alu_func;
	logic rd_mem, wr_mem, cond_branch, uncond_branch, csr_op, halt, illegal, valid_inst;
	logic [4:0] dest_idx, commit_idx;
	logic [31:0] rs1_value, rs2_value, commit_data;
	logic [TAG_BITS-1:0] rs1_tag, rs2_tag, dest_tag;
	logic stall, commit_valid;

	// reference model, written only by the checker
	logic [31:0] ref_regs [32];
	logic ref_known [32];
	logic [TAG_BITS-1:0] ref_map [32];
	logic [4:0] rob_dest [8];
	logic [31:0] rob_val [8];
	logic rob_done [8];
	logic [TAG_BITS-1:0] inflight [$]; // allocation order
	logic [TAG_BITS-1:0] exp_tag;
	logic [TAG_BITS-1:0] head_tag;
	logic exp_commit, exp_disp;
	logic drv_legal; // stimulus side knowledge of the driven inst
	logic [4:0] drv_dest;
	logic [31:0] lcg_state = 32'd6;

	issue_top #(.ROB_TAG_BITS(TAG_BITS)) DUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the test sequence finished");
		$display("TEST FAILED");
		$fatal(1);
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state ^ (lcg_state >> 16);
	endfunction

	function automatic logic [TAG_BITS-1:0] following_tag(input logic [TAG_BITS-1:0] t);
		return (t == 3'd7) ? 3'd1 : t + 3'd1; // tag 0 never allocated
	endfunction

	function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	task automatic mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_operand(input logic [4:0] idx, input logic [31:0] got, input string name);
		logic [TAG_BITS-1:0] t;
		logic [31:0] want;
		logic known;
		t = ref_map[idx];
		known = 1'b1;
		if (idx == 5'd0)
			want = '0;
		else if (t != '0 && rob_done[t])
			want = rob_val[t]; // forwarded from the buffer
		else begin
			want = ref_regs[idx];
			known = ref_known[idx];
		end
		if (known)
			assert (got == want) else mismatch($sformatf("%s = %h, expected %h", name, got, want));
	endtask

	always @(negedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				ref_map[i] = '0;
				ref_known[i] = 1'b0;
			end
			for (int i = 0; i < 8; i++)
				rob_done[i] = 1'b0;
			inflight.delete();
			exp_tag = 3'd1;
		end else begin
			head_tag = (inflight.size() > 0) ? inflight[0] : '0;
			exp_commit = inflight.size() > 0 && rob_done[head_tag];
			exp_disp = inst_valid && drv_legal && inflight.size() != LAST_TAG;
			assert (stall == (inflight.size() == LAST_TAG))
				else mismatch($sformatf("stall = %0b with %0d in flight", stall, inflight.size()));
			assert (rs1_tag == ref_map[inst[19:15]] && rs2_tag == ref_map[inst[24:20]])
				else mismatch($sformatf("rs tags %0d %0d", rs1_tag, rs2_tag));
			check_operand(inst[19:15], rs1_value, "rs1_value");
			check_operand(inst[24:20], rs2_value, "rs2_value");
			assert (commit_valid == exp_commit) else mismatch("commit_valid wrong");
			if (exp_commit)
				assert (commit_idx == rob_dest[head_tag] && commit_data == rob_val[head_tag])
					else mismatch($sformatf("commit x%0d = %h", commit_idx, commit_data));
			if (inst_valid && drv_legal)
				assert (dest_idx == drv_dest) else mismatch($sformatf("dest_idx %0d", dest_idx));
			if (exp_disp)
				assert (dest_tag == exp_tag)
					else mismatch($sformatf("dest_tag %0d, expected %0d", dest_tag, exp_tag));
			// next edge effects, commit before dispatch so a new mapping wins
			if (exp_commit) begin
				void'(inflight.pop_front());
				if (rob_dest[head_tag] != 5'd0) begin
					ref_regs[rob_dest[head_tag]] = rob_val[head_tag];
					ref_known[rob_dest[head_tag]] = 1'b1;
					if (ref_map[rob_dest[head_tag]] == head_tag)
						ref_map[rob_dest[head_tag]] = '0;
				end
				rob_done[head_tag] = 1'b0;
			end
			if (complete_valid) begin
				rob_val[complete_tag] = complete_data;
				rob_done[complete_tag] = 1'b1;
			end
			if (exp_disp) begin
				rob_dest[exp_tag] = drv_dest;
				rob_done[exp_tag] = 1'b0;
				if (drv_dest != 5'd0)
					ref_map[drv_dest] = exp_tag;
				inflight.push_back(exp_tag);
				exp_tag = following_tag(exp_tag);
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rst_n) stall |=> $stable(dest_tag))
		else mismatch("dest_tag advanced while stalled");
	assert property (@(posedge clock) disable iff (!rst_n) illegal |-> !valid_inst)
		else mismatch("valid_inst high on an illegal inst");
	assert property (@(posedge clock) disable iff (!rst_n) !inst_valid |-> !valid_inst && !illegal)
		else mismatch("decode active without inst_valid");

	// one cycle of stimulus, optionally completing a random pending tag
	task automatic drive(input logic [31:0] i, input logic v, input logic lg,
			input logic [4:0] d, input logic cpl);
		logic [TAG_BITS-1:0] pending [$];
		@(posedge clock);
		#2;
		inst = i;
		inst_valid = v;
		drv_legal = lg;
		drv_dest = d;
		complete_valid = 1'b0;
		foreach (inflight[k]) begin
			if (!rob_done[inflight[k]])
				pending.push_back(inflight[k]);
		end
		if (cpl && pending.size() > 0 && next_random() % 3 != 0) begin
			complete_tag = pending[next_random() % pending.size()];
			complete_data = next_random();
			complete_valid = 1'b1;
		end
	endtask

	// holds inst until consumed, returns just after the checker ran
	task automatic issue(input logic [31:0] i, input logic v, input logic lg,
			input logic [4:0] d, input logic cpl);
		drive(i, v, lg, d, cpl);
		@(negedge clock);
		#1;
		while (stall && v && lg) begin
			drive(i, v, lg, d, cpl);
			@(negedge clock);
			#1;
		end
	endtask

	task automatic complete(input logic [TAG_BITS-1:0] t, input logic [31:0] data);
		@(posedge clock);
		#2;
		inst_valid = 1'b0;
		complete_valid = 1'b1;
		complete_tag = t;
		complete_data = data;
	endtask

	task automatic drain();
		while (inflight.size() > 0)
			drive(32'h0, 1'b0, 1'b0, 5'd0, 1'b1);
	endtask

	// flags: rd_mem wr_mem cond uncond csr halt illegal valid
	task automatic check_decode(input logic [31:0] i, input logic v, input opa_sel_e a,
			input opb_sel_e b, input alu_func_e f, input logic [7:0] flags, input logic [4:0] d);
		issue(i, v, flags[0], d, 1'b1);
		assert (opa_sel == a && opb_sel == b && alu_func == f)
			else mismatch($sformatf("inst %h selects %0d %0d %0d", i, opa_sel, opb_sel, alu_func));
		assert ({rd_mem, wr_mem, cond_branch, uncond_branch, csr_op, halt, illegal, valid_inst}
			== flags) else mismatch($sformatf("inst %h flags wrong", i));
		assert (dest_idx == d) else mismatch($sformatf("inst %h dest_idx %0d", i, dest_idx));
	endtask

	initial begin
		logic [4:0] rd, ra, rb;
		logic [11:0] imm;
		logic [TAG_BITS-1:0] t_new;
		logic [31:0] bp_inst, fwd_data;
		inst = '0;
		inst_valid = 1'b0;
		complete_valid = 1'b0;
		complete_tag = '0;
		complete_data = '0;
		drv_legal = 1'b0;
		drv_dest = '0;
		rst_n = 1'b0;
		repeat (16) @(posedge clock);
		#2 rst_n = 1'b1;

		check_decode(enc(7'h12, 5'd1, 5'd2, 3'd0, 5'd3, OPC_LUI), 1, OPA_IS_ZERO, OPB_IS_U_IMM,
			ALU_ADD, 8'b0000_0001, 5'd3);
		check_decode(enc(7'h01, 5'd4, 5'd6, 3'd5, 5'd4, OPC_AUIPC), 1, OPA_IS_PC, OPB_IS_U_IMM,
			ALU_ADD, 8'b0000_0001, 5'd4);
		check_decode(enc(7'h20, 5'd8, 5'd9, 3'd1, 5'd1, OPC_JAL), 1, OPA_IS_PC, OPB_IS_J_IMM,
			ALU_ADD, 8'b0001_0001, 5'd1);
		check_decode(enc(7'h00, 5'd4, 5'd3, 3'd0, 5'd1, OPC_JALR), 1, OPA_IS_RS1, OPB_IS_I_IMM,
			ALU_ADD, 8'b0001_0001, 5'd1);
		check_decode(enc(7'h00, 5'd4, 5'd3, 3'd1, 5'd0, OPC_JALR), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_ADD, 8'b0000_0010, 5'd0);
		check_decode(enc(7'h00, 5'd1, 5'd3, 3'd0, 5'd8, OPC_BRANCH), 1, OPA_IS_PC, OPB_IS_B_IMM,
			ALU_ADD, 8'b0010_0001, 5'd0);
		check_decode(enc(7'h3f, 5'd4, 5'd1, 3'd6, 5'd2, OPC_BRANCH), 1, OPA_IS_PC, OPB_IS_B_IMM,
			ALU_ADD, 8'b0010_0001, 5'd0);
		check_decode(enc(7'h00, 5'd4, 5'd1, 3'd2, 5'd2, OPC_BRANCH), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_ADD, 8'b0000_0010, 5'd0);
		check_decode(enc(7'h00, 5'd8, 5'd3, 3'd2, 5'd5, OPC_LOAD), 1, OPA_IS_RS1, OPB_IS_I_IMM,
			ALU_ADD, 8'b1000_0001, 5'd5);
		check_decode(enc(7'h00, 5'd2, 5'd3, 3'd4, 5'd6, OPC_LOAD), 1, OPA_IS_RS1, OPB_IS_I_IMM,
			ALU_ADD, 8'b1000_0001, 5'd6);
		check_decode(enc(7'h00, 5'd5, 5'd3, 3'd2, 5'd4, OPC_STORE), 1, OPA_IS_RS1, OPB_IS_S_IMM,
			ALU_ADD, 8'b0100_0001, 5'd0);
		check_decode(enc(7'h00, 5'd7, 5'd5, 3'd0, 5'd9, OPC_OP_IMM), 1, OPA_IS_RS1, OPB_IS_I_IMM,
			ALU_ADD, 8'b0000_0001, 5'd9);
		check_decode(enc(7'h00, 5'd7, 5'd5, 3'd3, 5'd9, OPC_OP_IMM), 1, OPA_IS_RS1, OPB_IS_I_IMM,
			ALU_SLTU, 8'b0000_0001, 5'd9);
		check_decode(enc(7'h20, 5'd3, 5'd9, 3'd5, 5'd2, OPC_OP_IMM), 1, OPA_IS_RS1, OPB_IS_I_IMM,
			ALU_SRA, 8'b0000_0001, 5'd2);
		check_decode(enc(7'h00, 5'd2, 5'd9, 3'd0, 5'd3, OPC_OP), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_ADD, 8'b0000_0001, 5'd3);
		check_decode(enc(7'h20, 5'd2, 5'd9, 3'd0, 5'd3, OPC_OP), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_SUB, 8'b0000_0001, 5'd3);
		check_decode(enc(7'h00, 5'd3, 5'd1, 3'd4, 5'd7, OPC_OP), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_XOR, 8'b0000_0001, 5'd7);
		check_decode(enc(7'h01, 5'd5, 5'd6, 3'd0, 5'd8, OPC_OP), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_MUL, 8'b0000_0001, 5'd8);
		check_decode(enc(7'h01, 5'd5, 5'd6, 3'd1, 5'd8, OPC_OP), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_MULH, 8'b0000_0001, 5'd8);
		check_decode(enc(7'h01, 5'd5, 5'd6, 3'd2, 5'd8, OPC_OP), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_MULHSU, 8'b0000_0001, 5'd8);
		check_decode(enc(7'h01, 5'd5, 5'd6, 3'd3, 5'd8, OPC_OP), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_MULHU, 8'b0000_0001, 5'd8);
		check_decode(enc(7'h01, 5'd5, 5'd6, 3'd4, 5'd0, OPC_OP), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_ADD, 8'b0000_0010, 5'd0); // div is not decoded
		check_decode(enc(7'h18, 5'd0, 5'd1, 3'd2, 5'd0, OPC_SYSTEM), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_ADD, 8'b0000_1001, 5'd0);
		check_decode(32'h1050_0073, 1, OPA_IS_RS1, OPB_IS_RS2, ALU_ADD, 8'b0000_0101, 5'd0);
		check_decode(32'h0000_0073, 1, OPA_IS_RS1, OPB_IS_RS2, ALU_ADD, 8'b0000_0010, 5'd0);
		check_decode(enc(7'h00, 5'd1, 5'd2, 3'd0, 5'd0, 7'h7f), 1, OPA_IS_RS1, OPB_IS_RS2,
			ALU_ADD, 8'b0000_0010, 5'd0);
		check_decode(enc(7'h00, 5'd8, 5'd3, 3'd2, 5'd5, OPC_LOAD), 0, OPA_IS_RS1, OPB_IS_RS2,
			ALU_ADD, 8'b0000_0000, 5'd0);

		// rename, then forward from the buffer ahead of commit
		drain();
		issue(enc(7'h00, 5'd1, 5'd0, 3'd0, 5'd7, OPC_OP_IMM), 1'b1, 1'b1, 5'd7, 1'b0);
		issue(enc(7'h00, 5'd2, 5'd0, 3'd0, 5'd8, OPC_OP_IMM), 1'b1, 1'b1, 5'd8, 1'b0);
		t_new = inflight[inflight.size()-1];
		issue(enc(7'h00, 5'd8, 5'd8, 3'd0, 5'd9, OPC_OP), 1'b1, 1'b1, 5'd9, 1'b0);
		assert (rs1_tag == t_new) else mismatch("rs1_tag does not name the new producer");
		fwd_data = next_random();
		complete(t_new, fwd_data);
		issue(enc(7'h00, 5'd7, 5'd8, 3'd0, 5'd10, OPC_OP), 1'b1, 1'b1, 5'd10, 1'b0);
		assert (rs1_tag == t_new && rs1_value == fwd_data)
			else mismatch($sformatf("forwarded rs1_value %h", rs1_value));
		drain();
		issue(enc(7'h00, 5'd0, 5'd8, 3'd0, 5'd11, OPC_OP_IMM), 1'b1, 1'b1, 5'd11, 1'b1);
		assert (rs1_tag == '0 && rs1_value == fwd_data)
			else mismatch($sformatf("committed rs1_value %h", rs1_value));

		// register zero
		issue(enc(7'h00, 5'd5, 5'd0, 3'd0, 5'd0, OPC_OP_IMM), 1'b1, 1'b1, 5'd0, 1'b1);
		drain();
		issue(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd12, OPC_OP), 1'b1, 1'b1, 5'd12, 1'b1);
		assert (rs1_tag == '0 && rs2_tag == '0 && rs1_value == '0 && rs2_value == '0)
			else mismatch("register zero read back nonzero");

		// fill the buffer and hold
		drain();
		for (int n = 0; n < LAST_TAG; n++)
			issue(enc(7'h00, 5'd3, 5'd13, 3'd0, 5'(n + 13), OPC_OP_IMM), 1'b1, 1'b1, 5'(n + 13), 1'b0);
		bp_inst = enc(7'h00, 5'd13, 5'd14, 3'd0, 5'd20, OPC_OP);
		repeat (3) begin
			drive(bp_inst, 1'b1, 1'b1, 5'd20, 1'b0);
			@(negedge clock);
			#1;
			assert (stall) else mismatch("stall low with seven entries in flight");
		end
		complete(inflight[0], next_random());
		issue(bp_inst, 1'b1, 1'b1, 5'd20, 1'b1);

		// random stream with out of order completion
		repeat (40) begin
			rd = 5'(next_random() % 32);
			ra = 5'(next_random() % 32);
			rb = 5'(next_random() % 32);
			imm = 12'(next_random());
			if (next_random() % 2 == 0)
				issue(enc(7'h00, rb, ra, 3'd0, rd, OPC_OP), 1'b1, 1'b1, rd, 1'b1);
			else
				issue(enc(imm[11:5], imm[4:0], ra, 3'd0, rd, OPC_OP_IMM), 1'b1, 1'b1, rd, 1'b1);
		end
		drain();
		drive(32'h0, 1'b0, 1'b0, 5'd0, 1'b0);
		@(negedge clock);
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_top import issue_pkg::*; #(
	parameter int ROB_TAG_BITS = 3
) (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [XLEN-1:0]         inst,
	input  logic                    inst_valid,
	input  logic                    complete_valid,
	input  logic [ROB_TAG_BITS-1:0] complete_tag,
	input  logic [XLEN-1:0]         complete_data,
	output opa_sel_e                opa_sel,
	output opb_sel_e                opb_sel,
	output alu_func_e               alu_func,
	output logic                    rd_mem,
	output logic                    wr_mem,
	output logic                    cond_branch,
	output logic                    uncond_branch,
	output logic                    csr_op,
	output logic                    halt,
	output logic                    illegal,
	output logic                    valid_inst,
	output logic [REG_IDX_BITS-1:0] dest_idx,
	output logic [XLEN-1:0]         rs1_value,
	output logic [XLEN-1:0]         rs2_value,
	output logic [ROB_TAG_BITS-1:0] rs1_tag,
	output logic [ROB_TAG_BITS-1:0] rs2_tag,
	output logic [ROB_TAG_BITS-1:0] dest_tag,
	output logic                    stall,
	output logic                    commit_valid,
	output logic [REG_IDX_BITS-1:0] commit_idx,
	output logic [XLEN-1:0]         commit_data
);

	logic                       dispatch;
	logic                       full;
	logic                       rs1_ready;
	logic                       rs2_ready;
	logic [ROB_TAG_BITS-1:0]    map_rs1_tag;
	logic [ROB_TAG_BITS-1:0]    map_rs2_tag;
	logic [XLEN-1:0]            rs1_rob_value;
	logic [XLEN-1:0]            rs2_rob_value;
	logic [ROB_TAG_BITS-1:0]    commit_tag;
	logic [2**ROB_TAG_BITS-1:0] done_flags;

	assign stall = full;
	assign dispatch = valid_inst & ~stall; // consumed at this edge

	issue_stage #(.ROB_TAG_BITS(ROB_TAG_BITS)) issue_0 (
		.clock(clock), .inst(inst), .inst_valid(inst_valid),
		.rs1_map_tag(map_rs1_tag), .rs2_map_tag(map_rs2_tag),
		.rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
		.rs1_rob_value(rs1_rob_value), .rs2_rob_value(rs2_rob_value),
		.commit_valid(commit_valid), .commit_idx(commit_idx), .commit_data(commit_data),
		.opa_sel(opa_sel), .opb_sel(opb_sel), .alu_func(alu_func),
		.rd_mem(rd_mem), .wr_mem(wr_mem),
		.cond_branch(cond_branch), .uncond_branch(uncond_branch),
		.csr_op(csr_op), .halt(halt), .illegal(illegal),
		.dest_idx(dest_idx), .rs1_value(rs1_value), .rs2_value(rs2_value),
		.rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .valid_inst(valid_inst)
	);

	// rs1 and rs2 fields index the map directly
	map_table #(.ROB_TAG_BITS(ROB_TAG_BITS)) map_0 (
		.clock(clock), .rst_n(rst_n),
		.rs1_idx(inst[19:15]), .rs2_idx(inst[24:20]),
		.dispatch(dispatch), .dest_idx(dest_idx), .alloc_tag(dest_tag),
		.commit_valid(commit_valid), .commit_idx(commit_idx), .commit_tag(commit_tag),
		.done_flags(done_flags),
		.rs1_tag(map_rs1_tag), .rs2_tag(map_rs2_tag),
		.rs1_ready(rs1_ready), .rs2_ready(rs2_ready)
	);

	reorder_buf #(.ROB_TAG_BITS(ROB_TAG_BITS)) rob_0 (
		.clock(clock), .rst_n(rst_n),
		.dispatch(dispatch), .dest_idx(dest_idx),
		.complete_valid(complete_valid), .complete_tag(complete_tag),
		.complete_data(complete_data),
		.rs1_tag(map_rs1_tag), .rs2_tag(map_rs2_tag),
		.alloc_tag(dest_tag), .full(full), .done_flags(done_flags),
		.rs1_value(rs1_rob_value), .rs2_value(rs2_rob_value),
		.commit_valid(commit_valid), .commit_idx(commit_idx),
		.commit_data(commit_data), .commit_tag(commit_tag)
	);

endmodule

`default_nettype wire

// ==== source/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage import issue_pkg::*; #(
	parameter int ROB_TAG_BITS
) (
	input  logic                    clock,
	input  logic [XLEN-1:0]         inst,
	input  logic                    inst_valid,
	input  logic [ROB_TAG_BITS-1:0] rs1_map_tag,
	input  logic [ROB_TAG_BITS-1:0] rs2_map_tag,
	input  logic                    rs1_ready,
	input  logic                    rs2_ready,
	input  logic [XLEN-1:0]         rs1_rob_value,
	input  logic [XLEN-1:0]         rs2_rob_value,
	input  logic                    commit_valid,
	input  logic [REG_IDX_BITS-1:0] commit_idx,
	input  logic [XLEN-1:0]         commit_data,
	output opa_sel_e                opa_sel,
	output opb_sel_e                opb_sel,
	output alu_func_e               alu_func,
	output logic                    rd_mem,
	output logic                    wr_mem,
	output logic                    cond_branch,
	output logic                    uncond_branch,
	output logic                    csr_op,
	output logic                    halt,
	output logic                    illegal,
	output logic [REG_IDX_BITS-1:0] dest_idx,
	output logic [XLEN-1:0]         rs1_value,
	output logic [XLEN-1:0]         rs2_value,
	output logic [ROB_TAG_BITS-1:0] rs1_tag,
	output logic [ROB_TAG_BITS-1:0] rs2_tag,
	output logic                    valid_inst
);

	dest_sel_e       dest_sel;
	logic [XLEN-1:0] regf_rs1_value;
	logic [XLEN-1:0] regf_rs2_value;

	inst_decoder decoder_0 (
		.inst(inst),
		.inst_valid(inst_valid),
		.opa_sel(opa_sel),
		.opb_sel(opb_sel),
		.dest_sel(dest_sel),
		.alu_func(alu_func),
		.rd_mem(rd_mem),
		.wr_mem(wr_mem),
		.cond_branch(cond_branch),
		.uncond_branch(uncond_branch),
		.csr_op(csr_op),
		.halt(halt),
		.illegal(illegal),
		.valid_inst(valid_inst)
	);

	// written only by in-order commit
	regfile regf_0 (
		.clock(clock),
		.rda_idx(inst[19:15]),
		.rdb_idx(inst[24:20]),
		.wr_en(commit_valid),
		.wr_idx(commit_idx),
		.wr_data(commit_data),
		.rda_out(regf_rs1_value),
		.rdb_out(regf_rs2_value)
	);

	assign dest_idx = (dest_sel == DEST_RD) ? inst[11:7] : ZERO_REG;

	// finished but uncommitted results come out of the buffer
	assign rs1_value = (rs1_map_tag != '0 && rs1_ready) ? rs1_rob_value : regf_rs1_value;
	assign rs2_value = (rs2_map_tag != '0 && rs2_ready) ? rs2_rob_value : regf_rs2_value;

	assign rs1_tag = rs1_map_tag; // waiters match on these
	assign rs2_tag = rs2_map_tag;

endmodule

`default_nettype wire

// ==== source/reorder_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buf import issue_pkg::*; #(
	parameter int ROB_TAG_BITS
) (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       dispatch,
	input  logic [REG_IDX_BITS-1:0]    dest_idx,
	input  logic                       complete_valid,
	input  logic [ROB_TAG_BITS-1:0]    complete_tag,
	input  logic [XLEN-1:0]            complete_data,
	input  logic [ROB_TAG_BITS-1:0]    rs1_tag,
	input  logic [ROB_TAG_BITS-1:0]    rs2_tag,
	output logic [ROB_TAG_BITS-1:0]    alloc_tag,
	output logic                       full,
	output logic [2**ROB_TAG_BITS-1:0] done_flags,
	output logic [XLEN-1:0]            rs1_value,
	output logic [XLEN-1:0]            rs2_value,
	output logic                       commit_valid,
	output logic [REG_IDX_BITS-1:0]    commit_idx,
	output logic [XLEN-1:0]            commit_data,
	output logic [ROB_TAG_BITS-1:0]    commit_tag
);

	localparam int DEPTH = 2**ROB_TAG_BITS;
	localparam logic [ROB_TAG_BITS-1:0] LAST_TAG = ROB_TAG_BITS'(DEPTH - 1);

	logic [ROB_TAG_BITS-1:0] head_q;
	logic [ROB_TAG_BITS-1:0] tail_q;
	logic [ROB_TAG_BITS-1:0] count_q; // entries in use, at most LAST_TAG
	logic [DEPTH-1:0]        busy_q;
	logic [DEPTH-1:0]        done_q;
	logic [REG_IDX_BITS-1:0] dest_mem [DEPTH];
	logic [XLEN-1:0]         value_mem [DEPTH];

	// wraps from the last tag back to 1 since tag 0 is reserved
	function automatic logic [ROB_TAG_BITS-1:0] next_tag(input logic [ROB_TAG_BITS-1:0] t);
		return (t == LAST_TAG) ? ROB_TAG_BITS'(1) : t + ROB_TAG_BITS'(1);
	endfunction

	assign alloc_tag = tail_q;
	assign full = (count_q == LAST_TAG);
	assign done_flags = done_q;
	assign rs1_value = value_mem[rs1_tag];
	assign rs2_value = value_mem[rs2_tag];

	assign commit_valid = busy_q[head_q] & done_q[head_q];
	assign commit_idx = dest_mem[head_q];
	assign commit_data = value_mem[head_q];
	assign commit_tag = head_q;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head_q <= ROB_TAG_BITS'(1);
			tail_q <= ROB_TAG_BITS'(1);
			count_q <= '0;
			busy_q <= '0;
			done_q <= '0;
		end else begin
			if (dispatch) begin
				busy_q[tail_q] <= 1'b1;
				done_q[tail_q] <= 1'b0;
				tail_q <= next_tag(tail_q);
			end
			if (complete_valid)
				done_q[complete_tag] <= 1'b1;
			if (commit_valid) begin // head retires while tail may allocate
				busy_q[head_q] <= 1'b0;
				done_q[head_q] <= 1'b0;
				head_q <= next_tag(head_q);
			end
			count_q <= count_q + ROB_TAG_BITS'(dispatch) - ROB_TAG_BITS'(commit_valid);
		end
	end

	always_ff @(posedge clock) begin
		if (dispatch)
			dest_mem[tail_q] <= dest_idx;
		if (complete_valid)
			value_mem[complete_tag] <= complete_data;
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		complete_valid |-> busy_q[complete_tag] && !done_q[complete_tag])
		else $error("completion for free or finished tag %0d", complete_tag);

	assert property (@(posedge clock) disable iff (!rst_n) dispatch |-> !full)
		else $error("dispatch into a full reorder buffer");

endmodule

`default_nettype wire

// ==== source/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table import issue_pkg::*; #(
	parameter int ROB_TAG_BITS
) (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic [REG_IDX_BITS-1:0]   rs1_idx,
	input  logic [REG_IDX_BITS-1:0]   rs2_idx,
	input  logic                      dispatch,
	input  logic [REG_IDX_BITS-1:0]   dest_idx,
	input  logic [ROB_TAG_BITS-1:0]   alloc_tag,
	input  logic                      commit_valid,
	input  logic [REG_IDX_BITS-1:0]   commit_idx,
	input  logic [ROB_TAG_BITS-1:0]   commit_tag,
	input  logic [2**ROB_TAG_BITS-1:0] done_flags,
	output logic [ROB_TAG_BITS-1:0]   rs1_tag,
	output logic [ROB_TAG_BITS-1:0]   rs2_tag,
	output logic                      rs1_ready,
	output logic                      rs2_ready
);

	logic [ROB_TAG_BITS-1:0] tag_q [NUM_REGS]; // 0 means value sits in regfile

	always_ff @(posedge clock) begin
		for (int i = 0; i < NUM_REGS; i++) begin
			if (!rst_n)
				tag_q[i] <= '0;
			else if (dispatch && dest_idx != ZERO_REG && dest_idx == REG_IDX_BITS'(i))
				tag_q[i] <= alloc_tag; // newer producer wins over a commit clear
			else if (commit_valid && commit_idx == REG_IDX_BITS'(i) && tag_q[i] == commit_tag)
				tag_q[i] <= '0;
		end
	end

	assign rs1_tag = tag_q[rs1_idx];
	assign rs2_tag = tag_q[rs2_idx];

	// tag 0 has no buffer entry so its done flag stays low
	assign rs1_ready = done_flags[rs1_tag];
	assign rs2_ready = done_flags[rs2_tag];

	assert property (@(posedge clock) disable iff (!rst_n) tag_q[ZERO_REG] == '0)
		else $error("register zero was renamed to tag %0d", tag_q[ZERO_REG]);

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import issue_pkg::*; (
	input  logic                    clock,
	input  logic [REG_IDX_BITS-1:0] rda_idx,
	input  logic [REG_IDX_BITS-1:0] rdb_idx,
	input  logic                    wr_en,
	input  logic [REG_IDX_BITS-1:0] wr_idx,
	input  logic [XLEN-1:0]         wr_data,
	output logic [XLEN-1:0]         rda_out,
	output logic [XLEN-1:0]         rdb_out
);

	logic [XLEN-1:0] registers [NUM_REGS];

	// x0 reads as zero whatever the array holds
	assign rda_out = (rda_idx == ZERO_REG) ? '0 : registers[rda_idx];
	assign rdb_out = (rdb_idx == ZERO_REG) ? '0 : registers[rdb_idx];

	always_ff @(posedge clock) begin
		if (wr_en && wr_idx != ZERO_REG)
			registers[wr_idx] <= wr_data;
	end

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import issue_pkg::*; (
	input  logic [XLEN-1:0] inst,
	input  logic            inst_valid,
	output opa_sel_e        opa_sel,
	output opb_sel_e        opb_sel,
	output dest_sel_e       dest_sel,
	output alu_func_e       alu_func,
	output logic            rd_mem,
	output logic            wr_mem,
	output logic            cond_branch,
	output logic            uncond_branch,
	output logic            csr_op,
	output logic            halt,
	output logic            illegal,
	output logic            valid_inst
);

	localparam logic [XLEN-1:0] WFI_INST = 32'h1050_0073;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign valid_inst = inst_valid & ~illegal;

	always_comb begin
		// noop unless a legal encoding says otherwise
		opa_sel = OPA_IS_RS1;
		opb_sel = OPB_IS_RS2;
		dest_sel = DEST_NONE;
		alu_func = ALU_ADD;
		rd_mem = 1'b0;
		wr_mem = 1'b0;
		cond_branch = 1'b0;
		uncond_branch = 1'b0;
		csr_op = 1'b0;
		halt = 1'b0;
		illegal = 1'b0;
		if (inst_valid) begin
			case (opcode)
				OPC_LUI: begin
					dest_sel = DEST_RD;
					opa_sel = OPA_IS_ZERO;
					opb_sel = OPB_IS_U_IMM;
				end
				OPC_AUIPC: begin
					dest_sel = DEST_RD;
					opa_sel = OPA_IS_PC;
					opb_sel = OPB_IS_U_IMM;
				end
				OPC_JAL: begin
					dest_sel = DEST_RD;
					opa_sel = OPA_IS_PC;
					opb_sel = OPB_IS_J_IMM;
					uncond_branch = 1'b1;
				end
				OPC_JALR: begin
					if (funct3 == 3'b000) begin
						dest_sel = DEST_RD;
						opb_sel = OPB_IS_I_IMM;
						uncond_branch = 1'b1;
					end else
						illegal = 1'b1;
				end
				OPC_BRANCH: begin
					if (funct3[2:1] != 2'b01) begin // 010 and 011 unused
						opa_sel = OPA_IS_PC;
						opb_sel = OPB_IS_B_IMM;
						cond_branch = 1'b1;
					end else
						illegal = 1'b1;
				end
				OPC_LOAD: begin
					// lb lh lw lbu lhu
					if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
						dest_sel = DEST_RD;
						opb_sel = OPB_IS_I_IMM;
						rd_mem = 1'b1;
					end else
						illegal = 1'b1;
				end
				OPC_STORE: begin
					if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
						opb_sel = OPB_IS_S_IMM;
						wr_mem = 1'b1;
					end else
						illegal = 1'b1;
				end
				OPC_OP_IMM: begin
					dest_sel = DEST_RD;
					opb_sel = OPB_IS_I_IMM;
					case (funct3)
						3'b000: alu_func = ALU_ADD;
						3'b010: alu_func = ALU_SLT;
						3'b011: alu_func = ALU_SLTU;
						3'b100: alu_func = ALU_XOR;
						3'b110: alu_func = ALU_OR;
						3'b111: alu_func = ALU_AND;
						3'b001: begin // shamt in rs2 slot
							if (funct7 == 7'b0000000)
								alu_func = ALU_SLL;
							else
								illegal = 1'b1;
						end
						default: begin
							if (funct7 == 7'b0000000)
								alu_func = ALU_SRL;
							else if (funct7 == 7'b0100000)
								alu_func = ALU_SRA;
							else
								illegal = 1'b1;
						end
					endcase
				end
				OPC_OP: begin
					dest_sel = DEST_RD;
					case ({funct7, funct3})
						10'b0000000_000: alu_func = ALU_ADD;
						10'b0100000_000: alu_func = ALU_SUB;
						10'b0000000_001: alu_func = ALU_SLL;
						10'b0000000_010: alu_func = ALU_SLT;
						10'b0000000_011: alu_func = ALU_SLTU;
						10'b0000000_100: alu_func = ALU_XOR;
						10'b0000000_101: alu_func = ALU_SRL;
						10'b0100000_101: alu_func = ALU_SRA;
						10'b0000000_110: alu_func = ALU_OR;
						10'b0000000_111: alu_func = ALU_AND;
						10'b0000001_000: alu_func = ALU_MUL;
						10'b0000001_001: alu_func = ALU_MULH;
						10'b0000001_010: alu_func = ALU_MULHSU;
						10'b0000001_011: alu_func = ALU_MULHU;
						default: illegal = 1'b1; // div and rem have no unit here
					endcase
				end
				OPC_SYSTEM: begin
					if (inst == WFI_INST)
						halt = 1'b1;
					else if (funct3 inside {3'b001, 3'b010, 3'b011})
						csr_op = 1'b1; // csrrw csrrs csrrc
					else
						illegal = 1'b1;
				end
				default: illegal = 1'b1;
			endcase
		end
	end

	// at most one instruction class per decode
	always_comb begin
		assert ($onehot0({rd_mem, wr_mem, cond_branch, uncond_branch, csr_op, halt}))
			else $error("decoder raised more than one class for inst %h", inst);
	end

endmodule

`default_nettype wire

// ==== source/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

	localparam int XLEN = 32;
	localparam int REG_IDX_BITS = 5;
	localparam int NUM_REGS = 1 << REG_IDX_BITS;
	localparam logic [REG_IDX_BITS-1:0] ZERO_REG = '0;

	// major opcode field inst[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_MUL,
		ALU_MULH,
		ALU_MULHSU,
		ALU_MULHU
	} alu_func_e;

	typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2,
		OPB_IS_I_IMM,
		OPB_IS_S_IMM,
		OPB_IS_B_IMM,
		OPB_IS_U_IMM,
		OPB_IS_J_IMM
	} opb_sel_e;

	typedef enum logic {DEST_NONE, DEST_RD} dest_sel_e;

endpackage

`default_nettype wire
